//--- verilog/arcade_pkg.sv
// Shared constants for the clk_25 front end; scan codes are set 2 make codes, low byte only
`default_nettype none

package arcade_pkg;

	////////////////////////////////
	// Button byte bit positions, active low at the core
	////////////////////////////////
	localparam integer BTN_RIGHT  = 7;
	localparam integer BTN_LEFT   = 6;
	localparam integer BTN_ONE    = 5;
	localparam integer BTN_TWO    = 4;
	localparam integer BTN_FIRE   = 3;
	localparam integer BTN_COIN   = 2;
	localparam integer BTN_THRUST = 1;
	localparam integer BTN_SHIELD = 0;

	////////////////////////////////
	// Keyboard scan codes
	////////////////////////////////
	localparam logic [7:0] KEY_M     = 8'h3a;
	localparam logic [7:0] KEY_F1    = 8'h05;
	localparam logic [7:0] KEY_F2    = 8'h06;
	localparam logic [7:0] KEY_A     = 8'h1c;
	localparam logic [7:0] KEY_D     = 8'h23;
	localparam logic [7:0] KEY_F3    = 8'h04;
	localparam logic [7:0] KEY_L     = 8'h4b;
	localparam logic [7:0] KEY_K     = 8'h42;
	localparam logic [7:0] KEY_CTRL  = 8'h14;
	localparam logic [7:0] KEY_ALT   = 8'h11; // Left alt
	localparam logic [7:0] KEY_SPACE = 8'h29;
	localparam logic [7:0] KEY_1     = 8'h16; // MAME style start and coin keys
	localparam logic [7:0] KEY_2     = 8'h1e;
	localparam logic [7:0] KEY_5     = 8'h2e;
	localparam logic [7:0] KEY_6     = 8'h36;
	localparam logic [7:0] KEY_LEFT  = 8'h6b; // Arrows, extended or keypad
	localparam logic [7:0] KEY_RIGHT = 8'h74;

	// Keyboard report fields
	localparam integer PS2_TOGGLE  = 10; // Flips once per new report
	localparam integer PS2_PRESSED = 9;
	localparam integer PS2_EXT     = 8; // E0 prefix seen

	// Status word fields
	localparam integer ST_RESET    = 0;
	localparam integer ST_ASPECT   = 1; // 1 selects wide
	localparam integer ST_LANG_LO  = 3; // Two bits
	localparam integer ST_SHIPS_LO = 5; // Two bits

	localparam logic [7:0] ASPECT_ORIG_X = 8'd4;
	localparam logic [7:0] ASPECT_ORIG_Y = 8'd3;
	localparam logic [7:0] ASPECT_WIDE_X = 8'd16;
	localparam logic [7:0] ASPECT_WIDE_Y = 8'd9;

endpackage

`default_nettype wire

//--- verilog/key_state_if.sv
// Held keyboard button levels, 1 while held; no handshake, sampled every cycle by the sink
`default_nettype none

interface key_state_if;

	logic right;
	logic left;
	logic one_player;
	logic two_players;
	logic fire;
	logic coin;
	logic thrust;
	logic shield;

	// Decoder side
	modport source (
		output right, left, one_player, two_players,
		output fire, coin, thrust, shield
	);

	// Mapper side
	modport sink (
		input right, left, one_player, two_players,
		input fire, coin, thrust, shield
	);

endinterface

`default_nettype wire

//--- verilog/ps2_key_decoder.sv
// Report must be stable in clk_25; a toggle flip during reset is absorbed, not decoded
`default_nettype none

module ps2_key_decoder (
	input  wire logic        clk_25,
	input  wire logic        reset,
	input  wire logic [10:0] ps2_key,
	key_state_if.source      keys
);

	logic       prev_toggle; // Toggle bit seen last cycle
	logic       new_report;
	logic       pressed;
	logic       ext;
	logic [7:0] code;

	assign pressed    = ps2_key[arcade_pkg::PS2_PRESSED];
	assign ext        = ps2_key[arcade_pkg::PS2_EXT];
	assign code       = ps2_key[7:0];
	assign new_report = prev_toggle != ps2_key[arcade_pkg::PS2_TOGGLE];

	////////////////////////////////
	// Held levels
	////////////////////////////////
	always_ff @(posedge clk_25) begin
		if (reset) begin
			prev_toggle      <= ps2_key[arcade_pkg::PS2_TOGGLE]; // Track, don't replay old report
			keys.right       <= 1'b0;
			keys.left        <= 1'b0;
			keys.one_player  <= 1'b0;
			keys.two_players <= 1'b0;
			keys.fire        <= 1'b0;
			keys.coin        <= 1'b0;
			keys.thrust      <= 1'b0;
			keys.shield      <= 1'b0;
		end else begin
			prev_toggle <= ps2_key[arcade_pkg::PS2_TOGGLE];
			if (new_report) begin
				case (code)
					// Plain keys only match without the E0 prefix
					arcade_pkg::KEY_M, arcade_pkg::KEY_CTRL: begin
						if (!ext) keys.fire <= pressed;
					end
					arcade_pkg::KEY_F1, arcade_pkg::KEY_1: begin
						if (!ext) keys.one_player <= pressed;
					end
					arcade_pkg::KEY_F2, arcade_pkg::KEY_2: begin
						if (!ext) keys.two_players <= pressed;
					end
					arcade_pkg::KEY_A: begin
						if (!ext) keys.left <= pressed;
					end
					arcade_pkg::KEY_D: begin
						if (!ext) keys.right <= pressed;
					end
					arcade_pkg::KEY_F3, arcade_pkg::KEY_5, arcade_pkg::KEY_6: begin
						if (!ext) keys.coin <= pressed; // Three coin keys
					end
					arcade_pkg::KEY_L, arcade_pkg::KEY_ALT: begin
						if (!ext) keys.thrust <= pressed;
					end
					arcade_pkg::KEY_K, arcade_pkg::KEY_SPACE: begin
						if (!ext) keys.shield <= pressed;
					end
					// Arrows match with or without prefix
					arcade_pkg::KEY_LEFT:  keys.left  <= pressed;
					arcade_pkg::KEY_RIGHT: keys.right <= pressed;
					default: ; // Unmapped, levels hold
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/input_mapper.sv
// Joystick words in clk_25; only bits 0,1 and 4..7 are game buttons, bit 7 is start and coin
`default_nettype none

module input_mapper (
	input  wire logic        clk_25,
	input  wire logic        reset,
	input  wire logic [15:0] joy_0,
	input  wire logic [15:0] joy_1,
	key_state_if.sink        keys,
	output logic      [7:0]  buttons
);

	// Joystick bit positions
	localparam integer JOY_RIGHT  = 0;
	localparam integer JOY_LEFT   = 1;
	localparam integer JOY_FIRE   = 4;
	localparam integer JOY_THRUST = 5;
	localparam integer JOY_SHIELD = 6;
	localparam integer JOY_START  = 7; // Drives one_player and coin together

	logic [15:0] joy;          // Either player's stick
	logic [7:0]  buttons_next; // Active low

	assign joy = joy_0 | joy_1;

	always_comb begin
		buttons_next[arcade_pkg::BTN_RIGHT]  = ~(keys.right | joy[JOY_RIGHT]);
		buttons_next[arcade_pkg::BTN_LEFT]   = ~(keys.left | joy[JOY_LEFT]);
		buttons_next[arcade_pkg::BTN_ONE]    = ~(keys.one_player | joy[JOY_START]);
		buttons_next[arcade_pkg::BTN_TWO]    = ~keys.two_players; // Keyboard only
		buttons_next[arcade_pkg::BTN_FIRE]   = ~(keys.fire | joy[JOY_FIRE]);
		buttons_next[arcade_pkg::BTN_COIN]   = ~(keys.coin | joy[JOY_START]);
		buttons_next[arcade_pkg::BTN_THRUST] = ~(keys.thrust | joy[JOY_THRUST]);
		buttons_next[arcade_pkg::BTN_SHIELD] = ~(keys.shield | joy[JOY_SHIELD]);
	end

	always_ff @(posedge clk_25) begin
		if (reset)
			buttons <= 8'hff; // All released
		else
			buttons <= buttons_next;
	end

endmodule

`default_nettype wire

//--- verilog/core_control.sv
// All inputs assumed synchronous to clk_25; core_reset is held high for the whole local reset
`default_nettype none

module core_control (
	input  wire logic        clk_25,
	input  wire logic        reset,
	input  wire logic [31:0] status,
	input  wire logic        reset_btn,
	input  wire logic        ext_reset,
	input  wire logic        download,
	output logic             core_reset,
	output logic      [7:0]  aspect_x,
	output logic      [7:0]  aspect_y,
	output logic      [1:0]  lang,
	output logic      [1:0]  ships,
	output logic             led_user
);

	logic wide; // Wide aspect selected from the menu

	assign wide = status[arcade_pkg::ST_ASPECT];

	always_ff @(posedge clk_25) begin
		if (reset) begin
			core_reset <= 1'b1; // Keep the core held
			aspect_x   <= arcade_pkg::ASPECT_ORIG_X;
			aspect_y   <= arcade_pkg::ASPECT_ORIG_Y;
			lang       <= 2'd0;
			ships      <= 2'd0;
			led_user   <= 1'b0;
		end else begin
			// Any source holds the core in reset, ROM load included
			core_reset <= ext_reset | status[arcade_pkg::ST_RESET] | reset_btn | download;
			aspect_x   <= wide ? arcade_pkg::ASPECT_WIDE_X : arcade_pkg::ASPECT_ORIG_X;
			aspect_y   <= wide ? arcade_pkg::ASPECT_WIDE_Y : arcade_pkg::ASPECT_ORIG_Y;
			lang       <= status[arcade_pkg::ST_LANG_LO +: 2];  // English, German, French, Spanish
			ships      <= status[arcade_pkg::ST_SHIPS_LO +: 2];
			led_user   <= download; // Lit while loading
		end
	end

endmodule

`default_nettype wire

//--- verilog/av_formatter.sv
// Core video and audio in clk_25, one pixel per clock; COLOR_BITS up to 8, AUDIO_BITS up to 16
`default_nettype none

module av_formatter #(
	parameter integer COLOR_BITS = 3,
	parameter integer AUDIO_BITS = 8
) (
	input  wire logic                  clk_25,
	input  wire logic                  reset,
	input  wire logic [COLOR_BITS-1:0] core_r,
	input  wire logic [COLOR_BITS-1:0] core_g,
	input  wire logic [COLOR_BITS-1:0] core_b,
	input  wire logic                  core_hs,
	input  wire logic                  core_vs,
	input  wire logic                  core_de,
	input  wire logic [AUDIO_BITS-1:0] core_audio,
	output logic      [7:0]            vga_r,
	output logic      [7:0]            vga_g,
	output logic      [7:0]            vga_b,
	output logic                       vga_hs,
	output logic                       vga_vs,
	output logic                       vga_de,
	output logic      [7:0]            hdmi_r,
	output logic      [7:0]            hdmi_g,
	output logic      [7:0]            hdmi_b,
	output logic                       hdmi_hs,
	output logic                       hdmi_vs,
	output logic                       hdmi_de,
	output logic      [15:0]           audio_l,
	output logic      [15:0]           audio_r
);

	// Repeat from the MSB so full scale maps to 8'hff, abc gives abcabcab
	function automatic logic [7:0] widen_color(input logic [COLOR_BITS-1:0] c);
		logic [7:0] w;
		for (int i = 0; i < 8; i++)
			w[7-i] = c[COLOR_BITS-1 - (i % COLOR_BITS)];
		return w;
	endfunction

	// Same scheme for audio, 8 bits gives {a, a}
	function automatic logic [15:0] widen_audio(input logic [AUDIO_BITS-1:0] a);
		logic [15:0] w;
		for (int i = 0; i < 16; i++)
			w[15-i] = a[AUDIO_BITS-1 - (i % AUDIO_BITS)];
		return w;
	endfunction

	////////////////////////////////
	// Output registers
	////////////////////////////////
	always_ff @(posedge clk_25) begin
		if (reset) begin
			vga_r   <= 8'd0;
			vga_g   <= 8'd0;
			vga_b   <= 8'd0;
			vga_hs  <= 1'b0;
			vga_vs  <= 1'b0;
			vga_de  <= 1'b0; // Blank
			audio_l <= 16'd0;
		end else begin
			vga_r   <= widen_color(core_r);
			vga_g   <= widen_color(core_g);
			vga_b   <= widen_color(core_b);
			vga_hs  <= core_hs;
			vga_vs  <= ~core_vs; // Core vsync has the opposite polarity
			vga_de  <= core_de;
			audio_l <= widen_audio(core_audio);
		end
	end

	// Second video output and right channel share the same registers
	assign hdmi_r  = vga_r;
	assign hdmi_g  = vga_g;
	assign hdmi_b  = vga_b;
	assign hdmi_hs = vga_hs;
	assign hdmi_vs = vga_vs;
	assign hdmi_de = vga_de;
	assign audio_r = audio_l; // Mono game

endmodule

`default_nettype wire

//--- verilog/arcade_frontend.sv
// Single clk_25 domain, all inputs synchronous; keyboard reaches buttons in 2 cycles, others in 1
`default_nettype none

module arcade_frontend #(
	parameter integer COLOR_BITS = 3,
	parameter integer AUDIO_BITS = 8
) (
	input  wire logic                  clk_25,
	input  wire logic                  reset,
	// Host inputs
	input  wire logic [10:0]           ps2_key,
	input  wire logic [15:0]           joy_0,
	input  wire logic [15:0]           joy_1,
	input  wire logic [31:0]           status,
	input  wire logic                  reset_btn,
	input  wire logic                  ext_reset,
	input  wire logic                  download,
	// From the game core
	input  wire logic [COLOR_BITS-1:0] core_r,
	input  wire logic [COLOR_BITS-1:0] core_g,
	input  wire logic [COLOR_BITS-1:0] core_b,
	input  wire logic                  core_hs,
	input  wire logic                  core_vs,
	input  wire logic                  core_de,
	input  wire logic [AUDIO_BITS-1:0] core_audio,
	// To the game core
	output logic      [7:0]            buttons,
	output logic                       core_reset,
	output logic      [1:0]            lang,
	output logic      [1:0]            ships,
	// To the host
	output logic      [7:0]            aspect_x,
	output logic      [7:0]            aspect_y,
	output logic                       led_user,
	output logic      [7:0]            vga_r,
	output logic      [7:0]            vga_g,
	output logic      [7:0]            vga_b,
	output logic                       vga_hs,
	output logic                       vga_vs,
	output logic                       vga_de,
	output logic      [7:0]            hdmi_r,
	output logic      [7:0]            hdmi_g,
	output logic      [7:0]            hdmi_b,
	output logic                       hdmi_hs,
	output logic                       hdmi_vs,
	output logic                       hdmi_de,
	output logic      [15:0]           audio_l,
	output logic      [15:0]           audio_r
);

	key_state_if keys (); // Decoder to mapper

	////////////////////////////////
	// Inputs
	////////////////////////////////
	ps2_key_decoder ps2_key_decoder_i (
		.clk_25  (clk_25),
		.reset   (reset),
		.ps2_key (ps2_key),
		.keys    (keys.source)
	);

	input_mapper input_mapper_i (
		.clk_25  (clk_25),
		.reset   (reset),
		.joy_0   (joy_0),
		.joy_1   (joy_1),
		.keys    (keys.sink),
		.buttons (buttons)
	);

	core_control core_control_i (
		.clk_25     (clk_25),
		.reset      (reset),
		.status     (status),
		.reset_btn  (reset_btn),
		.ext_reset  (ext_reset),
		.download   (download),
		.core_reset (core_reset),
		.aspect_x   (aspect_x),
		.aspect_y   (aspect_y),
		.lang       (lang),
		.ships      (ships),
		.led_user   (led_user)
	);

	////////////////////////////////
	// Video and audio
	////////////////////////////////
	av_formatter #(
		.COLOR_BITS (COLOR_BITS),
		.AUDIO_BITS (AUDIO_BITS)
	) av_formatter_i (
		.clk_25     (clk_25),
		.reset      (reset),
		.core_r     (core_r),
		.core_g     (core_g),
		.core_b     (core_b),
		.core_hs    (core_hs),
		.core_vs    (core_vs),
		.core_de    (core_de),
		.core_audio (core_audio),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs),
		.vga_de     (vga_de),
		.hdmi_r     (hdmi_r),
		.hdmi_g     (hdmi_g),
		.hdmi_b     (hdmi_b),
		.hdmi_hs    (hdmi_hs),
		.hdmi_vs    (hdmi_vs),
		.hdmi_de    (hdmi_de),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

endmodule

`default_nettype wire

//--- tb/arcade_frontend_tb.sv
// Testbench for the default build only (3-bit colour, 8-bit audio); outputs are checked at negedge
`default_nettype none

module arcade_frontend_tb;

	localparam integer COLOR_BITS = 3;
	localparam integer AUDIO_BITS = 8;
	localparam integer NUM_CODES  = 17;
	localparam integer RAND_COUNT = 64;
	localparam integer NUM_TESTS  = 2 * NUM_CODES + 6 + 3 * RAND_COUNT;

	logic                  clk_25;
	logic                  reset;
	logic [10:0]           ps2_key;
	logic [15:0]           joy_0;
	logic [15:0]           joy_1;
	logic [31:0]           status;
	logic                  reset_btn;
	logic                  ext_reset;
	logic                  download;
	logic [COLOR_BITS-1:0] core_r;
	logic [COLOR_BITS-1:0] core_g;
	logic [COLOR_BITS-1:0] core_b;
	logic                  core_hs;
	logic                  core_vs;
	logic                  core_de;
	logic [AUDIO_BITS-1:0] core_audio;
	logic [7:0]            buttons;
	logic                  core_reset;
	logic [1:0]            lang;
	logic [1:0]            ships;
	logic [7:0]            aspect_x;
	logic [7:0]            aspect_y;
	logic                  led_user;
	logic [7:0]            vga_r;
	logic [7:0]            vga_g;
	logic [7:0]            vga_b;
	logic                  vga_hs;
	logic                  vga_vs;
	logic                  vga_de;
	logic [7:0]            hdmi_r;
	logic [7:0]            hdmi_g;
	logic [7:0]            hdmi_b;
	logic                  hdmi_hs;
	logic                  hdmi_vs;
	logic                  hdmi_de;
	logic [15:0]           audio_l;
	logic [15:0]           audio_r;

	integer seed        = 11;
	integer error_count = 0;
	integer check_count = 0;
	integer slot;
	logic   toggle_bit  = 1'b0; // Last toggle sent

	// Every mapped scan code with the arrows last
	logic [7:0] key_codes [NUM_CODES] = '{
		arcade_pkg::KEY_M, arcade_pkg::KEY_F1, arcade_pkg::KEY_F2, arcade_pkg::KEY_A,
		arcade_pkg::KEY_D, arcade_pkg::KEY_F3, arcade_pkg::KEY_L, arcade_pkg::KEY_K,
		arcade_pkg::KEY_CTRL, arcade_pkg::KEY_ALT, arcade_pkg::KEY_SPACE, arcade_pkg::KEY_1,
		arcade_pkg::KEY_2, arcade_pkg::KEY_5, arcade_pkg::KEY_6,
		arcade_pkg::KEY_LEFT, arcade_pkg::KEY_RIGHT
	};

	// Model state one edge behind the DUT registers
	logic [10:0] saved_ps2   = 11'd0;
	logic        saved_reset = 1'b1;
	logic [7:0]  m_keys      = 8'd0; // Held levels by button position
	logic        m_toggle    = 1'b0;

	// Expected outputs after the next edge
	logic [7:0]  exp_buttons    = 8'hff;
	logic        exp_core_reset = 1'b1;
	logic [15:0] exp_aspect     = {arcade_pkg::ASPECT_ORIG_X, arcade_pkg::ASPECT_ORIG_Y};
	logic [1:0]  exp_lang       = 2'd0;
	logic [1:0]  exp_ships      = 2'd0;
	logic        exp_led        = 1'b0;
	logic [7:0]  exp_r          = 8'd0;
	logic [7:0]  exp_g          = 8'd0;
	logic [7:0]  exp_b          = 8'd0;
	logic        exp_hs         = 1'b0;
	logic        exp_vs         = 1'b0;
	logic        exp_de         = 1'b0;
	logic [15:0] exp_audio      = 16'd0;

	arcade_frontend #(
		.COLOR_BITS (COLOR_BITS),
		.AUDIO_BITS (AUDIO_BITS)
	) arcade_frontend_i (.*);

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic logic [7:0] ref_buttons(input logic [7:0] k, input logic [15:0] j0,
			input logic [15:0] j1);
		logic [15:0] j;
		logic [7:0]  b;
		j = j0 | j1; // Either stick
		b[arcade_pkg::BTN_RIGHT]  = ~(k[arcade_pkg::BTN_RIGHT] | j[0]);
		b[arcade_pkg::BTN_LEFT]   = ~(k[arcade_pkg::BTN_LEFT] | j[1]);
		b[arcade_pkg::BTN_ONE]    = ~(k[arcade_pkg::BTN_ONE] | j[7]); // Start
		b[arcade_pkg::BTN_TWO]    = ~k[arcade_pkg::BTN_TWO];
		b[arcade_pkg::BTN_FIRE]   = ~(k[arcade_pkg::BTN_FIRE] | j[4]);
		b[arcade_pkg::BTN_COIN]   = ~(k[arcade_pkg::BTN_COIN] | j[7]); // Also start
		b[arcade_pkg::BTN_THRUST] = ~(k[arcade_pkg::BTN_THRUST] | j[5]);
		b[arcade_pkg::BTN_SHIELD] = ~(k[arcade_pkg::BTN_SHIELD] | j[6]);
		return b;
	endfunction

	// Button position for a code or -1 when nothing matches
	function automatic integer key_slot(input logic [7:0] code, input logic ext);
		if (code == arcade_pkg::KEY_LEFT) return arcade_pkg::BTN_LEFT; // Either prefix
		if (code == arcade_pkg::KEY_RIGHT) return arcade_pkg::BTN_RIGHT;
		if (ext) return -1;
		case (code)
			arcade_pkg::KEY_M, arcade_pkg::KEY_CTRL:    return arcade_pkg::BTN_FIRE;
			arcade_pkg::KEY_F1, arcade_pkg::KEY_1:      return arcade_pkg::BTN_ONE;
			arcade_pkg::KEY_F2, arcade_pkg::KEY_2:      return arcade_pkg::BTN_TWO;
			arcade_pkg::KEY_A:                          return arcade_pkg::BTN_LEFT;
			arcade_pkg::KEY_D:                          return arcade_pkg::BTN_RIGHT;
			arcade_pkg::KEY_F3, arcade_pkg::KEY_5,
			arcade_pkg::KEY_6:                          return arcade_pkg::BTN_COIN;
			arcade_pkg::KEY_L, arcade_pkg::KEY_ALT:     return arcade_pkg::BTN_THRUST;
			arcade_pkg::KEY_K, arcade_pkg::KEY_SPACE:   return arcade_pkg::BTN_SHIELD;
			default:                                    return -1;
		endcase
	endfunction

	function automatic logic [7:0] expand_color(input logic [2:0] c);
		logic [8:0] rep;
		rep = {c, c, c}; // abcabcabc, drop the last bit
		return rep[8:1];
	endfunction

	function automatic logic [15:0] expand_audio(input logic [7:0] a);
		return {a, a};
	endfunction

	function automatic logic ref_core_reset(input logic [31:0] st, input logic btn,
			input logic ext_rst, input logic dl);
		return st[arcade_pkg::ST_RESET] | btn | ext_rst | dl;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] want);
		check_count = check_count + 1;
		if (got !== want) begin
			error_count = error_count + 1;
			$display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	//////////////////////////////
	// Clock and watchdog
	//////////////////////////////
	initial begin
		clk_25 = 1'b0;
		forever #2 clk_25 = ~clk_25;
	end

	initial begin
		repeat (NUM_TESTS * 40 + 200) @(posedge clk_25);
		$display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * 40 + 200);
		$display("Checks %0d, errors %0d", check_count, error_count);
		$display("Simulation finished: FAIL");
		$finish;
	end

	//////////////////////////////
	// Compare at negedge where outputs are stable
	//////////////////////////////
	always @(negedge clk_25) begin
		check_value("buttons", buttons, exp_buttons);
		check_value("core_reset", core_reset, exp_core_reset);
		check_value("aspect", {aspect_x, aspect_y}, exp_aspect);
		check_value("lang", lang, exp_lang);
		check_value("ships", ships, exp_ships);
		check_value("led_user", led_user, exp_led);
		check_value("vga colour", {vga_r, vga_g, vga_b}, {exp_r, exp_g, exp_b});
		check_value("hdmi colour", {hdmi_r, hdmi_g, hdmi_b}, {exp_r, exp_g, exp_b});
		check_value("vga sync", {vga_hs, vga_vs, vga_de}, {exp_hs, exp_vs, exp_de});
		check_value("hdmi sync", {hdmi_hs, hdmi_vs, hdmi_de}, {exp_hs, exp_vs, exp_de});
		check_value("audio_l", audio_l, exp_audio);
		check_value("audio_r", audio_r, exp_audio);
		// Decoder stage sees the report one edge earlier
		if (saved_reset) begin
			m_keys   = 8'd0;
			m_toggle = saved_ps2[arcade_pkg::PS2_TOGGLE]; // Absorbed
		end else begin
			if (saved_ps2[arcade_pkg::PS2_TOGGLE] != m_toggle) begin
				slot = key_slot(saved_ps2[7:0], saved_ps2[arcade_pkg::PS2_EXT]);
				if (slot >= 0) m_keys[slot] = saved_ps2[arcade_pkg::PS2_PRESSED];
			end
			m_toggle = saved_ps2[arcade_pkg::PS2_TOGGLE];
		end
		if (reset) begin
			exp_buttons    = 8'hff;
			exp_core_reset = 1'b1;
			exp_aspect     = {arcade_pkg::ASPECT_ORIG_X, arcade_pkg::ASPECT_ORIG_Y};
			exp_lang       = 2'd0;
			exp_ships      = 2'd0;
			exp_led        = 1'b0;
			{exp_r, exp_g, exp_b} = 24'd0;
			{exp_hs, exp_vs, exp_de} = 3'b000;
			exp_audio      = 16'd0;
		end else begin
			exp_buttons    = ref_buttons(m_keys, joy_0, joy_1);
			exp_core_reset = ref_core_reset(status, reset_btn, ext_reset, download);
			exp_aspect     = status[arcade_pkg::ST_ASPECT] ? 16'h1009 : 16'h0403; // 16:9 or 4:3
			exp_lang       = status[arcade_pkg::ST_LANG_LO +: 2];
			exp_ships      = status[arcade_pkg::ST_SHIPS_LO +: 2];
			exp_led        = download;
			exp_r          = expand_color(core_r);
			exp_g          = expand_color(core_g);
			exp_b          = expand_color(core_b);
			exp_hs         = core_hs;
			exp_vs         = ~core_vs;
			exp_de         = core_de;
			exp_audio      = expand_audio(core_audio);
		end
		saved_ps2   = ps2_key;
		saved_reset = reset;
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	task automatic send_report(input logic pressed, input logic ext, input logic [7:0] code);
		toggle_bit = ~toggle_bit; // New report
		ps2_key <= {toggle_bit, pressed, ext, code};
		repeat (3) @(posedge clk_25);
	endtask

	// Arrows get a random prefix bit
	task automatic send_key(input logic [7:0] code, input logic pressed);
		logic [31:0] r;
		logic        ext;
		r   = $random(seed);
		ext = (code == arcade_pkg::KEY_LEFT || code == arcade_pkg::KEY_RIGHT) ? r[0] : 1'b0;
		send_report(pressed, ext, code);
	endtask

	initial begin
		logic [31:0] r;
		reset      = 1'b1;
		ps2_key    = 11'd0;
		joy_0      = 16'd0;
		joy_1      = 16'd0;
		status     = 32'd0;
		reset_btn  = 1'b0;
		ext_reset  = 1'b0;
		download   = 1'b0;
		core_r     = '0;
		core_g     = '0;
		core_b     = '0;
		core_hs    = 1'b0;
		core_vs    = 1'b0;
		core_de    = 1'b0;
		core_audio = '0;
		repeat (8) @(posedge clk_25);
		reset <= 1'b0;
		@(posedge clk_25);

		// Press and release each key on its own so every code moves its level
		for (int i = 0; i < NUM_CODES; i++) begin
			send_key(key_codes[i], 1'b1);
			send_key(key_codes[i], 1'b0);
		end
		ps2_key <= {toggle_bit, 1'b1, 1'b0, arcade_pkg::KEY_D}; // Same toggle, ignored
		repeat (3) @(posedge clk_25);
		send_report(1'b1, 1'b1, arcade_pkg::KEY_M); // Prefixed plain key
		send_report(1'b1, 1'b0, 8'h55);             // Unmapped
		send_report(1'b1, 1'b1, arcade_pkg::KEY_LEFT);
		send_report(1'b0, 1'b0, arcade_pkg::KEY_LEFT);

		// Sticks with random key traffic
		joy_0 <= 16'h0080; // Start bit alone
		@(posedge clk_25);
		for (int i = 0; i < RAND_COUNT; i++) begin
			r = $random(seed) & $random(seed); // Sparse bits
			joy_0 <= r[15:0];
			joy_1 <= r[31:16];
			r = $random(seed);
			if (i % 3 == 0) send_key(key_codes[$unsigned($random(seed)) % NUM_CODES], r[0]);
			else @(posedge clk_25);
		end
		joy_0 <= 16'd0;
		joy_1 <= 16'd0;

		for (int i = 0; i < RAND_COUNT; i++) begin
			r = $random(seed);
			status    <= $random(seed);
			reset_btn <= r[3:0] == 4'd0; // Rare, core_reset not stuck
			ext_reset <= r[7:4] == 4'd0;
			download  <= r[11:8] == 4'd0;
			@(posedge clk_25);
		end
		reset_btn <= 1'b0;
		ext_reset <= 1'b0;
		download  <= 1'b0;

		for (int i = 0; i < RAND_COUNT; i++) begin
			r = $random(seed);
			core_r     <= r[2:0];
			core_g     <= r[5:3];
			core_b     <= r[8:6];
			core_hs    <= r[9];
			core_vs    <= r[10];
			core_de    <= r[11];
			core_audio <= r[19:12];
			@(posedge clk_25);
		end

		repeat (4) @(posedge clk_25); // Drain the pipeline
		$display("Checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- arcade_frontend.f
verilog/arcade_pkg.sv
verilog/key_state_if.sv
verilog/ps2_key_decoder.sv
verilog/input_mapper.sv
verilog/core_control.sv
verilog/av_formatter.sv
verilog/arcade_frontend.sv
tb/arcade_frontend_tb.sv
